/* common/tsc_cfg.svh */
`ifndef TSC_CFG_SVH
`define TSC_CFG_SVH

// data path and instruction width
`define TSC_WORD_SIZE 16

// architectural registers r0..r3
`define TSC_NUM_REGS 4

// opcode 4'hf with all fields zero
`define TSC_NOP_INST 16'hf000

`endif

/* common/tsc_pkg.sv */
`include "tsc_cfg.svh"

package tsc_pkg;

	typedef logic [`TSC_WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`TSC_NUM_REGS)-1:0] reg_idx_t;

	// instruction bits 15:12
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_ORR = 4'h3,
		OP_ADI = 4'h4,
		OP_LHI = 4'h5,
		OP_BEQ = 4'h6,
		OP_BNE = 4'h7,
		OP_NOP = 4'hf
	} opcode_e;

	// fetched instruction and its pc
	typedef struct packed {
		word_t inst;
		word_t pc;
	} if_id_t;

	// decoded instruction with register operands already read
	typedef struct packed {
		opcode_e  op;
		word_t    a;
		word_t    b;
		word_t    imm;
		word_t    pc;
		reg_idx_t dest;
		logic     writes_reg;
	} id_ex_t;

	// retiring register write
	typedef struct packed {
		reg_idx_t dest;
		word_t    result;
	} ex_wb_t;

endpackage

/* hw/pipe_latch.sv */
`timescale 1ns/1ps

module pipe_latch #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	input  logic     hold,
	input  logic     flush,
	output logic     out_valid,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// hold wins over flush and a flushed stage becomes a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (!hold) begin
			valid_q <= flush ? 1'b0 : in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

	// a held entry must not change under the consumer
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && hold) |=> $stable(out_data)
	);

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input  logic              if_id_valid,
	input  tsc_pkg::if_id_t   if_id_data,
	input  logic              id_ex_valid,
	input  tsc_pkg::reg_idx_t id_ex_dest,
	input  logic              id_ex_writes,
	input  logic              branch_taken,
	output logic              stall,
	output logic              flush
);

	import tsc_pkg::*;

	reg_idx_t rs;
	reg_idx_t rt;
	logic     uses_rs;
	logic     uses_rt;

	assign rs = if_id_data.inst[11:10];
	assign rt = if_id_data.inst[9:8];

	// which source fields the younger instruction actually reads
	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (if_id_data.inst[15:12])
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_BEQ, OP_BNE: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_ADI: begin
				uses_rs = 1'b1;
			end
			default: begin
				uses_rs = 1'b0;
				uses_rt = 1'b0;
			end
		endcase
	end

	// producer still in execute and the regfile not yet written
	assign stall = if_id_valid && id_ex_valid && id_ex_writes &&
		((uses_rs && rs == id_ex_dest) || (uses_rt && rt == id_ex_dest));

	assign flush = branch_taken;

	// branches never write a register, so a taken branch cannot also stall
	a_no_stall_flush: assert final (!(stall && flush));

endmodule

/* decode/decode_stage.sv */
`timescale 1ns/1ps
`include "tsc_cfg.svh"

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  tsc_pkg::if_id_t   if_id,
	input  logic              wr_en,
	input  tsc_pkg::reg_idx_t wr_reg,
	input  tsc_pkg::word_t    wr_data,
	output tsc_pkg::id_ex_t   id_ex
);

	import tsc_pkg::*;

	word_t    regs [`TSC_NUM_REGS];
	word_t    inst;
	logic     legal;
	opcode_e  op;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	reg_idx_t dest;
	logic     writes;
	word_t    imm;
	word_t    rs_val;
	word_t    rt_val;

	// unknown opcodes are decoded as a nop
	assign legal = if_id.inst[15:12] inside {OP_ADD, OP_SUB, OP_AND, OP_ORR,
		OP_ADI, OP_LHI, OP_BEQ, OP_BNE, OP_NOP};
	assign inst = legal ? if_id.inst : `TSC_NOP_INST;

	assign op  = opcode_e'(inst[15:12]);
	assign rs  = inst[11:10];
	assign rt  = inst[9:8];
	assign rd  = inst[7:6];
	assign imm = {{8{inst[7]}}, inst[7:0]};

	always_comb begin
		dest   = rd;
		writes = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_ORR: begin
				dest   = rd;
				writes = 1'b1;
			end
			OP_ADI, OP_LHI: begin
				dest   = rt;
				writes = 1'b1;
			end
			default: begin
				dest   = rd;
				writes = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `TSC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// a retiring result is written through in the same cycle
	assign rs_val = (wr_en && wr_reg == rs) ? wr_data : regs[rs];
	assign rt_val = (wr_en && wr_reg == rt) ? wr_data : regs[rt];

	always_comb begin
		id_ex = '{
			op:         op,
			a:          rs_val,
			b:          rt_val,
			imm:        imm,
			pc:         if_id.pc,
			dest:       dest,
			writes_reg: writes
		};
	end

	// writeback is only driven from a valid ex/wb entry, which reset clears
	a_no_write_in_reset: assert property (
		@(posedge clk) !rst_n |-> !wr_en
	);

endmodule

/* hw/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
	input  tsc_pkg::id_ex_t id_ex,
	output tsc_pkg::ex_wb_t result,
	output logic            writes_reg,
	output logic            branch_taken,
	output tsc_pkg::word_t  branch_target
);

	import tsc_pkg::*;

	word_t value;

	always_comb begin
		value        = '0;
		branch_taken = 1'b0;
		case (id_ex.op)
			OP_ADD: value = id_ex.a + id_ex.b;
			OP_SUB: value = id_ex.a - id_ex.b;
			OP_AND: value = id_ex.a & id_ex.b;
			OP_ORR: value = id_ex.a | id_ex.b;
			OP_ADI: value = id_ex.a + id_ex.imm;
			// lower byte cleared
			OP_LHI: value = {id_ex.imm[7:0], 8'h00};
			OP_BEQ: branch_taken = (id_ex.a == id_ex.b);
			OP_BNE: branch_taken = (id_ex.a != id_ex.b);
			default: begin
				value        = '0;
				branch_taken = 1'b0;
			end
		endcase
	end

	// pc+1+imm
	assign branch_target = id_ex.pc + word_t'(1) + id_ex.imm;

	// branches and nops were decoded without a destination
	assign writes_reg = id_ex.writes_reg;

	assign result = '{dest: id_ex.dest, result: value};

endmodule

/* hw/tsc_pipe.sv */
`timescale 1ns/1ps

module tsc_pipe (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  tsc_pkg::word_t    in_inst,
	input  tsc_pkg::word_t    in_pc,
	output logic              wb_valid,
	input  logic              wb_ready,
	output tsc_pkg::reg_idx_t wb_reg,
	output tsc_pkg::word_t    wb_data,
	output logic              redirect_valid,
	output tsc_pkg::word_t    redirect_pc
);

	import tsc_pkg::*;

	logic   hold;
	logic   stall;
	logic   flush;
	logic   wr_en;

	if_id_t if_id_in;
	if_id_t if_id_q;
	logic   if_id_valid;

	id_ex_t id_ex_d;
	id_ex_t id_ex_q;
	logic   id_ex_valid;

	ex_wb_t ex_wb_d;
	ex_wb_t ex_wb_q;
	logic   ex_wb_valid;

	logic   alu_writes;
	logic   alu_taken;
	logic   branch_taken;
	word_t  branch_target;

	// output back-pressure freezes every stage
	assign hold     = wb_valid && !wb_ready;
	assign in_ready = !(hold || stall || flush);
	assign if_id_in = '{inst: in_inst, pc: in_pc};

	pipe_latch #(.payload_t(if_id_t)) u_if_id (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (if_id_in),
		.hold      (hold || stall),
		.flush     (flush),
		.out_valid (if_id_valid),
		.out_data  (if_id_q)
	);

	decode_stage u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.if_id   (if_id_q),
		.wr_en   (wr_en),
		.wr_reg  (wb_reg),
		.wr_data (wb_data),
		.id_ex   (id_ex_d)
	);

	// a stall leaves a bubble behind the waiting instruction
	pipe_latch #(.payload_t(id_ex_t)) u_id_ex (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (if_id_valid),
		.in_data   (id_ex_d),
		.hold      (hold),
		.flush     (flush || stall),
		.out_valid (id_ex_valid),
		.out_data  (id_ex_q)
	);

	alu_stage u_alu (
		.id_ex         (id_ex_q),
		.result        (ex_wb_d),
		.writes_reg    (alu_writes),
		.branch_taken  (alu_taken),
		.branch_target (branch_target)
	);

	assign branch_taken = id_ex_valid && alu_taken;

	hazard_unit u_hazard (
		.if_id_valid  (if_id_valid),
		.if_id_data   (if_id_q),
		.id_ex_valid  (id_ex_valid),
		.id_ex_dest   (id_ex_q.dest),
		.id_ex_writes (id_ex_q.writes_reg),
		.branch_taken (branch_taken),
		.stall        (stall),
		.flush        (flush)
	);

	// only register writes reach the writeback port
	pipe_latch #(.payload_t(ex_wb_t)) u_ex_wb (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (id_ex_valid && alu_writes),
		.in_data   (ex_wb_d),
		.hold      (hold),
		.flush     (1'b0),
		.out_valid (ex_wb_valid),
		.out_data  (ex_wb_q)
	);

	assign wb_valid = ex_wb_valid;
	assign wb_reg   = ex_wb_q.dest;
	assign wb_data  = ex_wb_q.result;
	assign wr_en    = wb_valid && wb_ready;

	// a held branch would otherwise repeat its redirect
	assign redirect_valid = branch_taken && !hold;
	assign redirect_pc    = branch_target;

	// the flush empties id/ex, so a redirect never lasts two cycles
	a_redirect_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect_valid |=> !redirect_valid
	);

endmodule

/* verification/tsc_pipe_tb.sv */
`timescale 1ns/1ps
`include "tsc_cfg.svh"

module tsc_pipe_tb;

	import tsc_pkg::*;

	localparam int NUM_TESTS   = 6;
	localparam int TOTAL_INSTS = 4 + 8 + 7 + 24 + 6 + 4;
	// worst case per instruction is a stall plus random writeback back-pressure
	localparam int CYCLE_LIMIT = 10 + TOTAL_INSTS * 12 + NUM_TESTS * 16;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	word_t    in_inst;
	word_t    in_pc;
	logic     wb_valid;
	logic     wb_ready;
	reg_idx_t wb_reg;
	word_t    wb_data;
	logic     redirect_valid;
	word_t    redirect_pc;

	// program memory of the fetch source indexed by pc
	word_t    prog [32];
	int       prog_len;

	// software register model and the expected output streams
	word_t    model_regs [`TSC_NUM_REGS];
	reg_idx_t exp_reg [$];
	word_t    exp_data [$];
	word_t    exp_target [$];

	int seed = 96697;
	int cycle_count = 0;
	int stalls_seen;
	int holds_seen;

	tsc_pipe u_tsc_pipe (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_inst        (in_inst),
		.in_pc          (in_pc),
		.wb_valid       (wb_valid),
		.wb_ready       (wb_ready),
		.wb_reg         (wb_reg),
		.wb_data        (wb_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	always #10 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			stop_with_failure($sformatf("timeout after %0d cycles, the tests did not finish",
				cycle_count));
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERROR: time %0t %s got 0x%0h expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	function automatic word_t rtype_word(input opcode_e op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
		return {op, rs, rt, rd, 6'b000000};
	endfunction

	function automatic word_t itype_word(input opcode_e op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic expect_write(input reg_idx_t r, input word_t v);
		model_regs[r] = v;
		exp_reg.push_back(r);
		exp_data.push_back(v);
	endtask

	// walks the program in architectural order and follows taken branches
	task automatic model_execute();
		int       pc;
		int       steps;
		word_t    w;
		word_t    imm;
		word_t    a;
		word_t    b;
		word_t    target;
		logic     taken;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		pc = 0;
		steps = 0;
		exp_reg.delete();
		exp_data.delete();
		exp_target.delete();
		while (pc < prog_len && steps < 64) begin
			w = prog[pc];
			rs = w[11:10];
			rt = w[9:8];
			rd = w[7:6];
			imm = {{8{w[7]}}, w[7:0]};
			a = model_regs[rs];
			b = model_regs[rt];
			taken = 1'b0;
			steps++;
			case (w[15:12])
				OP_ADD: expect_write(rd, a + b);
				OP_SUB: expect_write(rd, a - b);
				OP_AND: expect_write(rd, a & b);
				OP_ORR: expect_write(rd, a | b);
				OP_ADI: expect_write(rt, a + imm);
				OP_LHI: expect_write(rt, {w[7:0], 8'h00});
				OP_BEQ: taken = (a == b);
				OP_BNE: taken = (a != b);
				default: taken = 1'b0;
			endcase
			if (taken) begin
				target = word_t'(pc + 1) + imm;
				exp_target.push_back(target);
				pc = target;
			end else begin
				pc++;
			end
		end
	endtask

	// acts as fetch source and writeback sink with one loop pass per cycle
	task automatic run_program(input logic random_ready);
		int src_pc;
		int idle;
		int rnd;
		src_pc = 0;
		idle = 0;
		stalls_seen = 0;
		holds_seen = 0;
		model_execute();
		while (idle < 6) begin
			@(negedge clk);
			rnd = $random(seed);
			in_valid = (src_pc < prog_len);
			in_inst = in_valid ? prog[src_pc] : `TSC_NOP_INST;
			in_pc = word_t'(src_pc);
			wb_ready = random_ready ? rnd[0] : 1'b1;
			#1;
			if (wb_valid && wb_ready) begin
				if (exp_reg.size() == 0) begin
					stop_with_failure("a writeback appeared when no result was expected");
				end
				check_value("wb_reg", wb_reg, exp_reg.pop_front());
				check_value("wb_data", wb_data, exp_data.pop_front());
			end
			if (wb_valid && !wb_ready) begin
				holds_seen++;
			end
			if (in_valid && !in_ready) begin
				stalls_seen++;
			end
			if (redirect_valid) begin
				if (exp_target.size() == 0) begin
					stop_with_failure("a redirect appeared for a branch that should not be taken");
				end
				check_value("redirect_pc", redirect_pc, exp_target.pop_front());
				check_value("in_ready", in_ready, 0);
				src_pc = redirect_pc;
			end else if (in_valid && in_ready) begin
				src_pc++;
			end
			if (src_pc >= prog_len && exp_reg.size() == 0 && exp_target.size() == 0) begin
				idle++;
			end else begin
				idle = 0;
			end
		end
	endtask

	task automatic test_reset_state();
		#1;
		check_value("wb_valid", wb_valid, 0);
		check_value("redirect_valid", redirect_valid, 0);
		@(negedge clk);
		#1;
		check_value("in_ready", in_ready, 1);
		// every register is read before anything is written
		prog_len = 4;
		prog[0] = rtype_word(OP_ADD, 2'd0, 2'd1, 2'd0);
		prog[1] = rtype_word(OP_ADD, 2'd2, 2'd3, 2'd1);
		prog[2] = rtype_word(OP_ADD, 2'd3, 2'd2, 2'd2);
		prog[3] = rtype_word(OP_ADD, 2'd1, 2'd0, 2'd3);
		run_program(1'b0);
	endtask

	task automatic test_alu_ops();
		prog_len = 8;
		prog[0] = itype_word(OP_LHI, 2'd0, 2'd0, 8'h12);
		prog[1] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h34);
		prog[2] = itype_word(OP_ADI, 2'd3, 2'd2, 8'h05);
		prog[3] = itype_word(OP_ADI, 2'd0, 2'd3, 8'hff);
		prog[4] = rtype_word(OP_ADD, 2'd1, 2'd2, 2'd0);
		prog[5] = rtype_word(OP_SUB, 2'd2, 2'd3, 2'd1);
		prog[6] = rtype_word(OP_AND, 2'd0, 2'd1, 2'd2);
		prog[7] = rtype_word(OP_ORR, 2'd0, 2'd1, 2'd3);
		run_program(1'b0);
	endtask

	task automatic test_raw_hazard();
		prog_len = 7;
		prog[0] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h01);
		prog[1] = itype_word(OP_ADI, 2'd1, 2'd1, 8'h01);
		prog[2] = itype_word(OP_ADI, 2'd1, 2'd1, 8'h02);
		prog[3] = itype_word(OP_ADI, 2'd1, 2'd1, 8'h03);
		prog[4] = itype_word(OP_ADI, 2'd1, 2'd1, 8'h04);
		prog[5] = itype_word(OP_ADI, 2'd1, 2'd1, 8'hf8);
		prog[6] = rtype_word(OP_ADD, 2'd1, 2'd1, 2'd2);
		run_program(1'b0);
		check_value("stall cycles seen", stalls_seen > 0, 1);
	endtask

	task automatic test_backpressure();
		logic [1:0] a;
		logic [1:0] b;
		logic [1:0] c;
		logic [7:0] k;
		prog_len = 24;
		for (int i = 0; i < 24; i++) begin
			a = i[1:0];
			b = a + 2'd1;
			c = a + 2'd2;
			k = i[7:0] * 8'd7 + 8'd3;
			case (i % 6)
				0: prog[i] = itype_word(OP_ADI, b, a, k);
				1: prog[i] = rtype_word(OP_ADD, a, b, c);
				2: prog[i] = rtype_word(OP_SUB, c, a, b);
				3: prog[i] = itype_word(OP_LHI, a, c, k);
				4: prog[i] = rtype_word(OP_AND, b, c, a);
				default: prog[i] = rtype_word(OP_ORR, a, c, b);
			endcase
		end
		run_program(1'b1);
		check_value("hold cycles seen", holds_seen > 0, 1);
	endtask

	task automatic test_taken_branch();
		prog_len = 6;
		prog[0] = itype_word(OP_LHI, 2'd0, 2'd0, 8'h05);
		prog[1] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h05);
		prog[2] = itype_word(OP_BEQ, 2'd0, 2'd1, 8'h02);
		// skipped by the branch to pc 5
		prog[3] = itype_word(OP_ADI, 2'd2, 2'd2, 8'h01);
		prog[4] = itype_word(OP_ADI, 2'd3, 2'd3, 8'h01);
		prog[5] = itype_word(OP_ADI, 2'd0, 2'd2, 8'h03);
		run_program(1'b0);
	endtask

	task automatic test_not_taken_branch();
		prog_len = 4;
		prog[0] = itype_word(OP_LHI, 2'd0, 2'd0, 8'h0a);
		prog[1] = itype_word(OP_LHI, 2'd0, 2'd1, 8'h0a);
		prog[2] = itype_word(OP_BNE, 2'd0, 2'd1, 8'h02);
		prog[3] = itype_word(OP_ADI, 2'd0, 2'd2, 8'h01);
		run_program(1'b0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_inst = `TSC_NOP_INST;
		in_pc = '0;
		wb_ready = 1'b1;
		prog_len = 0;
		for (int i = 0; i < `TSC_NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_alu_ops();
		test_raw_hazard();
		test_backpressure();
		test_taken_branch();
		test_not_taken_branch();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* tsc_pipe.f */
+incdir+common
common/tsc_pkg.sv
hw/pipe_latch.sv
hw/hazard_unit.sv
decode/decode_stage.sv
hw/alu_stage.sv
hw/tsc_pipe.sv
verification/tsc_pipe_tb.sv

/* Bender.yml */
package:
  name: tsc_pipe

sources:
  - include_dirs:
      - common
    files:
      - common/tsc_pkg.sv
      - hw/pipe_latch.sv
      - hw/hazard_unit.sv
      - decode/decode_stage.sv
      - hw/alu_stage.sv
      - hw/tsc_pipe.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tsc_pipe_tb.sv
